// ==== rv_backend_pkg.sv ====
package rv_backend_pkg;

    // Datapath width
    localparam int XLEN = 32;

    // Register file geometry
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    // Data memory geometry, word organized
    localparam int DMEM_WORDS  = 256;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    // Bytes per word, for lane enables
    localparam int BYTES_PER_WORD = XLEN / 8;

    // Writeback result source
    // Order matches the result mux inputs
    typedef enum logic [2:0] {
        RES_ALU       = 3'd0,
        RES_PC_TARGET = 3'd1,
        RES_PC_PLUS4  = 3'd2,
        RES_IMM       = 3'd3,
        RES_MEM       = 3'd4
    } result_src_e;

    // Load/store width, same code as funct3
    // Unsigned variants only make sense for loads
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_op_e;

endpackage

// ==== mem_wb_if.sv ====
interface mem_wb_if;

    import rv_backend_pkg::*;

    // Data fields
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       reduced_data;
    logic [XLEN-1:0]       pc_target;
    logic [XLEN-1:0]       pc_plus4;
    logic [XLEN-1:0]       imm_ext;
    logic [REG_ADDR_W-1:0] rd;

    // Control fields
    result_src_e           result_src;
    logic                  reg_write;

    // Memory stage drives
    modport mem_side (
        output alu_result, reduced_data, pc_target, pc_plus4, imm_ext, rd,
        output result_src, reg_write
    );

    // Writeback stage samples
    modport wb_side (
        input alu_result, reduced_data, pc_target, pc_plus4, imm_ext, rd,
        input result_src, reg_write
    );

endinterface

// ==== load_reducer.sv ====
module load_reducer (
    input  logic [rv_backend_pkg::XLEN-1:0] word_i,
    input  logic [1:0]                      byte_off_i,
    input  rv_backend_pkg::mem_op_e         mem_op_i,
    output logic [rv_backend_pkg::XLEN-1:0] data_o
);

    import rv_backend_pkg::*;

    // Addressed byte or half moved down to bit 0
    logic [XLEN-1:0] shifted;
    logic [7:0]      byte_val;
    logic [15:0]     half_val;

    // Offset in bytes, scaled to bits
    assign shifted  = word_i >> {byte_off_i, 3'b000};
    assign byte_val = shifted[7:0];
    assign half_val = shifted[15:0];

    always_comb begin
        unique case (mem_op_i)
            // Signed byte
            MEM_B:   data_o = {{(XLEN-8){byte_val[7]}}, byte_val};
            // Signed half
            MEM_H:   data_o = {{(XLEN-16){half_val[15]}}, half_val};
            // Full word, no shift needed
            MEM_W:   data_o = word_i;
            // Zero extended byte
            MEM_BU:  data_o = {{(XLEN-8){1'b0}}, byte_val};
            // Zero extended half
            MEM_HU:  data_o = {{(XLEN-16){1'b0}}, half_val};
            // Undefined op passes raw word
            default: data_o = word_i;
        endcase
    end

endmodule

// ==== data_memory.sv ====
module data_memory (
    input  logic                                   clk_i,
    input  logic                                   we_i,
    input  logic [rv_backend_pkg::BYTES_PER_WORD-1:0] be_i,
    input  logic [rv_backend_pkg::DMEM_ADDR_W-1:0] addr_i,
    input  logic [rv_backend_pkg::XLEN-1:0]        wdata_i,
    output logic [rv_backend_pkg::XLEN-1:0]        rdata_o
);

    import rv_backend_pkg::*;

    // Word array, contents undefined at power up
    logic [XLEN-1:0] mem [DMEM_WORDS];

    // Byte lane writes on the clock edge
    // Lanes with be_i low keep their old byte
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int lane = 0; lane < BYTES_PER_WORD; lane++) begin
                if (be_i[lane]) begin
                    mem[addr_i][8*lane +: 8] <= wdata_i[8*lane +: 8];
                end
            end
        end
    end

    // Asynchronous read of the addressed word
    assign rdata_o = mem[addr_i];

    // Store steering upstream must select at least one lane
    a_we_has_lanes : assert property (
        @(posedge clk_i) we_i |-> (be_i != '0)
    ) else $error("data_memory: write enable with no byte lanes");

endmodule

// ==== memory_stage.sv ====
module memory_stage (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  stall_i,

    // Execute stage results
    input  logic [rv_backend_pkg::XLEN-1:0]       alu_result_e_i,
    input  logic [rv_backend_pkg::XLEN-1:0]       write_data_e_i,
    input  logic [rv_backend_pkg::XLEN-1:0]       pc_target_e_i,
    input  logic [rv_backend_pkg::XLEN-1:0]       pc_plus4_e_i,
    input  logic [rv_backend_pkg::XLEN-1:0]       imm_ext_e_i,
    input  logic [rv_backend_pkg::REG_ADDR_W-1:0] rd_e_i,

    // Execute stage control
    input  rv_backend_pkg::result_src_e           result_src_e_i,
    input  rv_backend_pkg::mem_op_e               mem_op_e_i,
    input  logic                                  reg_write_e_i,
    input  logic                                  mem_write_e_i,

    mem_wb_if.mem_side                            mw
);

    import rv_backend_pkg::*;

    // Memory pipeline register, payload
    logic [XLEN-1:0]       alu_result_m;
    logic [XLEN-1:0]       write_data_m;
    logic [XLEN-1:0]       pc_target_m;
    logic [XLEN-1:0]       pc_plus4_m;
    logic [XLEN-1:0]       imm_ext_m;

    // Memory pipeline register, control
    logic [REG_ADDR_W-1:0] rd_m;
    result_src_e           result_src_m;
    mem_op_e               mem_op_m;
    logic                  reg_write_m;
    logic                  mem_write_m;

    // Store steering and load path
    logic [1:0]                byte_off;
    logic [BYTES_PER_WORD-1:0] store_be;
    logic [XLEN-1:0]           store_data;
    logic [XLEN-1:0]           read_word;
    logic [XLEN-1:0]           reduced_data_m;

    // Alignment check
    logic access_m;
    logic aligned_m;

    // Control fields cleared on reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_m         <= '0;
            result_src_m <= RES_ALU;
            mem_op_m     <= MEM_W;
            reg_write_m  <= 1'b0;
            mem_write_m  <= 1'b0;
        end else if (!stall_i) begin
            rd_m         <= rd_e_i;
            result_src_m <= result_src_e_i;
            mem_op_m     <= mem_op_e_i;
            reg_write_m  <= reg_write_e_i;
            mem_write_m  <= mem_write_e_i;
        end
    end

    // Payload just follows the enable
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            alu_result_m <= alu_result_e_i;
            write_data_m <= write_data_e_i;
            pc_target_m  <= pc_target_e_i;
            pc_plus4_m   <= pc_plus4_e_i;
            imm_ext_m    <= imm_ext_e_i;
        end
    end

    assign byte_off = alu_result_m[1:0];

    // Replicate store data across lanes, enable only the target ones
    always_comb begin
        unique case (mem_op_m)
            MEM_B: begin
                store_data = {BYTES_PER_WORD{write_data_m[7:0]}};
                store_be   = 4'b0001 << byte_off;
            end
            MEM_H: begin
                store_data = {2{write_data_m[15:0]}};
                store_be   = 4'b0011 << {byte_off[1], 1'b0};
            end
            MEM_W: begin
                store_data = write_data_m;
                store_be   = 4'b1111;
            end
            // No store form for unsigned widths
            default: begin
                store_data = write_data_m;
                store_be   = '0;
            end
        endcase
    end

    // Word index from address bits above the byte offset
    data_memory u_data_memory (
        .clk_i   (clk_i),
        .we_i    (mem_write_m),
        .be_i    (store_be),
        .addr_i  (alu_result_m[DMEM_ADDR_W+1:2]),
        .wdata_i (store_data),
        .rdata_o (read_word)
    );

    load_reducer u_load_reducer (
        .word_i     (read_word),
        .byte_off_i (byte_off),
        .mem_op_i   (mem_op_m),
        .data_o     (reduced_data_m)
    );

    // Hand off to writeback
    assign mw.alu_result   = alu_result_m;
    assign mw.reduced_data = reduced_data_m;
    assign mw.pc_target    = pc_target_m;
    assign mw.pc_plus4     = pc_plus4_m;
    assign mw.imm_ext      = imm_ext_m;
    assign mw.rd           = rd_m;
    assign mw.result_src   = result_src_m;
    assign mw.reg_write    = reg_write_m;

    // A load is a register write sourced from memory
    assign access_m = mem_write_m || (reg_write_m && (result_src_m == RES_MEM));

    always_comb begin
        unique case (mem_op_m)
            MEM_H, MEM_HU: aligned_m = ~alu_result_m[0];
            MEM_W:         aligned_m = (alu_result_m[1:0] == 2'b00);
            default:       aligned_m = 1'b1;
        endcase
    end

    // No misaligned trap in this back end
    a_natural_align : assert property (
        @(posedge clk_i) disable iff (rst_i) access_m |-> aligned_m
    ) else $error("memory_stage: misaligned access at %h", alu_result_m);

endmodule

// ==== writeback_stage.sv ====
module writeback_stage (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  stall_i,

    mem_wb_if.wb_side                             mw,

    output logic [rv_backend_pkg::XLEN-1:0]       result_w_o,
    output logic [rv_backend_pkg::REG_ADDR_W-1:0] rd_w_o,
    output logic                                  reg_write_w_o
);

    import rv_backend_pkg::*;

    // Writeback pipeline register, payload
    logic [XLEN-1:0] alu_result_w;
    logic [XLEN-1:0] reduced_data_w;
    logic [XLEN-1:0] pc_target_w;
    logic [XLEN-1:0] pc_plus4_w;
    logic [XLEN-1:0] imm_ext_w;

    // Writeback pipeline register, control
    result_src_e     result_src_w;

    // Control cleared so no write leaks out of reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_w_o        <= '0;
            result_src_w  <= RES_ALU;
            reg_write_w_o <= 1'b0;
        end else if (!stall_i) begin
            rd_w_o        <= mw.rd;
            result_src_w  <= mw.result_src;
            reg_write_w_o <= mw.reg_write;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            alu_result_w   <= mw.alu_result;
            reduced_data_w <= mw.reduced_data;
            pc_target_w    <= mw.pc_target;
            pc_plus4_w     <= mw.pc_plus4;
            imm_ext_w      <= mw.imm_ext;
        end
    end

    // Result select
    always_comb begin
        unique case (result_src_w)
            RES_ALU:       result_w_o = alu_result_w;
            // Branch or jump target, e.g. auipc
            RES_PC_TARGET: result_w_o = pc_target_w;
            // Link value for jal and jalr
            RES_PC_PLUS4:  result_w_o = pc_plus4_w;
            // lui
            RES_IMM:       result_w_o = imm_ext_w;
            RES_MEM:       result_w_o = reduced_data_w;
            default:       result_w_o = alu_result_w;
        endcase
    end

    // Raw select comes from top level cast, so codes 5 to 7 can appear
    a_result_src_defined : assert property (
        @(posedge clk_i) disable iff (rst_i)
        reg_write_w_o |-> (result_src_w inside {RES_ALU, RES_PC_TARGET, RES_PC_PLUS4,
                                                RES_IMM, RES_MEM})
    ) else $error("writeback_stage: undefined result source %0d", result_src_w);

endmodule

// ==== register_file.sv ====
module register_file (
    input  logic                                  clk_i,
    input  logic                                  rst_i,

    // Write port from writeback
    input  logic                                  wr_en_i,
    input  logic [rv_backend_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [rv_backend_pkg::XLEN-1:0]       wr_data_i,

    // Read ports
    input  logic [rv_backend_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_backend_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_backend_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_backend_pkg::XLEN-1:0]       rs2_data_o
);

    import rv_backend_pkg::*;

    // Architectural registers x0 to x31
    logic [XLEN-1:0] regs [NUM_REGS];

    // x0 only ever gets the reset value
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // Asynchronous reads
    // A same-cycle write shows up only after the edge
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    // Covers every write that arrives from writeback
    a_x0_zero : assert property (
        @(posedge clk_i) disable iff (rst_i) regs[0] == '0
    ) else $error("register_file: x0 holds %h", regs[0]);

endmodule

// ==== rv_backend_top.sv ====
module rv_backend_top (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  stall_i,

    // Execute stage results
    input  logic [rv_backend_pkg::XLEN-1:0]       alu_result_e_i,
    input  logic [rv_backend_pkg::XLEN-1:0]       write_data_e_i,
    input  logic [rv_backend_pkg::XLEN-1:0]       pc_target_e_i,
    input  logic [rv_backend_pkg::XLEN-1:0]       pc_plus4_e_i,
    input  logic [rv_backend_pkg::XLEN-1:0]       imm_ext_e_i,
    input  logic [rv_backend_pkg::REG_ADDR_W-1:0] rd_e_i,

    // Execute stage control, raw codes
    input  logic [2:0]                            result_src_e_i,
    input  logic [2:0]                            mem_op_e_i,
    input  logic                                  reg_write_e_i,
    input  logic                                  mem_write_e_i,

    // Register read addresses
    input  logic [rv_backend_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_backend_pkg::REG_ADDR_W-1:0] rs2_addr_i,

    // Writeback results
    output logic [rv_backend_pkg::XLEN-1:0]       result_w_o,
    output logic [rv_backend_pkg::REG_ADDR_W-1:0] rd_w_o,
    output logic                                  reg_write_w_o,

    // Register read data
    output logic [rv_backend_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_backend_pkg::XLEN-1:0]       rs2_data_o
);

    import rv_backend_pkg::*;

    // Raw selects as package enums
    result_src_e result_src_sel;
    mem_op_e     mem_op_sel;

    assign result_src_sel = result_src_e'(result_src_e_i);
    assign mem_op_sel     = mem_op_e'(mem_op_e_i);

    // Memory to writeback bundle
    mem_wb_if mw_if ();

    memory_stage u_memory_stage (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .stall_i        (stall_i),
        .alu_result_e_i (alu_result_e_i),
        .write_data_e_i (write_data_e_i),
        .pc_target_e_i  (pc_target_e_i),
        .pc_plus4_e_i   (pc_plus4_e_i),
        .imm_ext_e_i    (imm_ext_e_i),
        .rd_e_i         (rd_e_i),
        .result_src_e_i (result_src_sel),
        .mem_op_e_i     (mem_op_sel),
        .reg_write_e_i  (reg_write_e_i),
        .mem_write_e_i  (mem_write_e_i),
        .mw             (mw_if.mem_side)
    );

    writeback_stage u_writeback_stage (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .mw            (mw_if.wb_side),
        .result_w_o    (result_w_o),
        .rd_w_o        (rd_w_o),
        .reg_write_w_o (reg_write_w_o)
    );

    // Writeback outputs feed the write port directly
    register_file u_register_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wr_en_i    (reg_write_w_o),
        .wr_addr_i  (rd_w_o),
        .wr_data_i  (result_w_o),
        .rs1_addr_i (rs1_addr_i),
        .rs2_addr_i (rs2_addr_i),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

endmodule

// ==== tb_rv_backend.sv ====
module tb_rv_backend;

    import rv_backend_pkg::*;

    localparam logic [31:0] SEED        = 32'h71af9cdf;
    localparam int          DRAIN_LIMIT = 40;

    // One expected writeback slot
    typedef struct packed {
        logic        valid;
        logic        rw;
        logic [4:0]  rd;
        logic [31:0] result;
    } slot_t;

    // DUT inputs
    logic        clk_i;
    logic        rst_i;
    logic        stall_i;
    logic [31:0] alu_result_e_i;
    logic [31:0] write_data_e_i;
    logic [31:0] pc_target_e_i;
    logic [31:0] pc_plus4_e_i;
    logic [31:0] imm_ext_e_i;
    logic [4:0]  rd_e_i;
    logic [2:0]  result_src_e_i;
    logic [2:0]  mem_op_e_i;
    logic        reg_write_e_i;
    logic        mem_write_e_i;
    logic [4:0]  rs1_addr_i;
    logic [4:0]  rs2_addr_i;

    // DUT outputs
    logic [31:0] result_w_o;
    logic [4:0]  rd_w_o;
    logic        reg_write_w_o;
    logic [31:0] rs1_data_o;
    logic [31:0] rs2_data_o;

    // Architectural model
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [DMEM_WORDS];

    // Issued slots, then the two modeled pipeline registers
    slot_t exp_q [$];
    slot_t stage_m;
    slot_t stage_w;
    int    in_flight;

    // Bookkeeping
    int    n_checks;
    int    n_errors;
    int    base_checks;
    int    base_errors;
    bit    timed_out;
    string cur_test;

    rv_backend_top dut (.*);

    always #4 clk_i = ~clk_i;

    // Load extraction by width and sign
    function automatic logic [31:0] load_value(input logic [2:0] op, input logic [1:0] off,
                                               input logic [31:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = word[16*off[1] +: 16];
        case (op)
            MEM_B:   load_value = {{24{b[7]}}, b};
            MEM_BU:  load_value = {24'h0, b};
            MEM_H:   load_value = {{16{h[15]}}, h};
            MEM_HU:  load_value = {16'h0, h};
            default: load_value = word;
        endcase
    endfunction

    // Expected writeback value of one instruction
    function automatic logic [31:0] ref_result(input logic [2:0] src, input logic [2:0] op,
                                               input logic [31:0] alu, input logic [31:0] pct,
                                               input logic [31:0] pc4, input logic [31:0] imm,
                                               input logic [31:0] word);
        case (src)
            RES_PC_TARGET: ref_result = pct;
            RES_PC_PLUS4:  ref_result = pc4;
            RES_IMM:       ref_result = imm;
            RES_MEM:       ref_result = load_value(op, alu[1:0], word);
            default:       ref_result = alu;
        endcase
    endfunction

    // Byte lane merge into the model memory
    task automatic apply_store(input logic [31:0] addr, input logic [31:0] data,
                               input logic [2:0] op);
        case (op)
            MEM_B:   model_mem[addr[9:2]][8*addr[1:0] +: 8] = data[7:0];
            MEM_H:   model_mem[addr[9:2]][16*addr[1] +: 16] = data[15:0];
            default: model_mem[addr[9:2]] = data;
        endcase
    endtask

    function automatic logic [4:0] rand_rd();
        rand_rd = $urandom_range(31, 1);
    endfunction

    // Random upper bits, word index and byte offset below
    function automatic logic [31:0] mem_addr(input int idx, input int off);
        mem_addr = ($urandom & 32'hffff_fc00) | (idx << 2) | off;
    endfunction

    // Natural alignment per width
    function automatic int load_offset(input logic [2:0] op);
        case (op)
            MEM_W:         load_offset = 0;
            MEM_H, MEM_HU: load_offset = 2 * $urandom_range(1, 0);
            default:       load_offset = $urandom_range(3, 0);
        endcase
    endfunction

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        n_errors++;
        $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
    endtask

    task automatic issue(input logic [2:0] src, input logic [2:0] op, input logic rw,
                         input logic mw, input logic [4:0] rd, input logic [31:0] alu,
                         input logic [31:0] wdata);
        logic [31:0] pct;
        logic [31:0] pc4;
        logic [31:0] imm;
        slot_t       e;
        pct      = $urandom;
        pc4      = $urandom;
        imm      = $urandom;
        e.valid  = 1'b1;
        e.rw     = rw;
        e.rd     = rd;
        // Earlier stores already merged, so memory order holds
        e.result = ref_result(src, op, alu, pct, pc4, imm, model_mem[alu[9:2]]);
        @(posedge clk_i);
        stall_i        <= 1'b0;
        alu_result_e_i <= alu;
        write_data_e_i <= wdata;
        pc_target_e_i  <= pct;
        pc_plus4_e_i   <= pc4;
        imm_ext_e_i    <= imm;
        rd_e_i         <= rd;
        result_src_e_i <= src;
        mem_op_e_i     <= op;
        reg_write_e_i  <= rw;
        mem_write_e_i  <= mw;
        exp_q.push_back(e);
        in_flight++;
        if (mw) begin
            apply_store(alu, wdata, op);
        end
        if (rw && (rd != 5'd0)) begin
            model_regs[rd] = e.result;
        end
    endtask

    // Empty slots, also the drain at the end of each test
    task automatic bubble(input int n);
        repeat (n) begin
            issue(RES_ALU, MEM_W, 1'b0, 1'b0, 5'd0, 32'h0, 32'h0);
        end
    endtask

    // Junk on the inputs must be ignored while frozen
    task automatic hold_pipeline(input int n);
        repeat (n) begin
            @(posedge clk_i);
            stall_i        <= 1'b1;
            alu_result_e_i <= $urandom;
            rd_e_i         <= rand_rd();
            result_src_e_i <= RES_ALU;
            reg_write_e_i  <= 1'b1;
            mem_write_e_i  <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((in_flight != 0 || exp_q.size() != 0) && cycles < DRAIN_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (in_flight != 0 || exp_q.size() != 0) begin
            timed_out = 1'b1;
            $display("Timeout: pipeline did not drain in test %s", cur_test);
        end
    endtask

    // Sweep both read ports over all registers
    task automatic check_regs();
        wait_drain();
        if (!timed_out) begin
            for (int i = 0; i < 32; i++) begin
                @(posedge clk_i);
                rs1_addr_i <= i;
                rs2_addr_i <= 31 - i;
                @(negedge clk_i);
                n_checks++;
                if (rs1_data_o !== model_regs[i]) begin
                    mismatch($sformatf("rs1 x%0d", i), model_regs[i], rs1_data_o);
                end
                n_checks++;
                if (rs2_data_o !== model_regs[31-i]) begin
                    mismatch($sformatf("rs2 x%0d", 31 - i), model_regs[31-i], rs2_data_o);
                end
            end
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        base_checks = n_checks;
        base_errors = n_errors;
    endtask

    task automatic end_test();
        $display("Test %s done: %0d checks, %0d errors", cur_test,
                 n_checks - base_checks, n_errors - base_errors);
    endtask

    task automatic reset_state();
        begin_test("reset");
        @(negedge clk_i);
        n_checks++;
        if (reg_write_w_o !== 1'b0) begin
            mismatch("reg_write_w_o", 32'h0, reg_write_w_o);
        end
        check_regs();
        end_test();
    endtask

    task automatic random_alu_writes();
        begin_test("alu");
        repeat (20) begin
            issue(RES_ALU, MEM_W, 1'b1, 1'b0, rand_rd(), $urandom, 32'h0);
        end
        bubble(2);
        check_regs();
        end_test();
    endtask

    task automatic result_sources();
        begin_test("sources");
        repeat (4) begin
            issue(RES_PC_TARGET, MEM_W, 1'b1, 1'b0, rand_rd(), $urandom, 32'h0);
            issue(RES_PC_PLUS4, MEM_W, 1'b1, 1'b0, rand_rd(), $urandom, 32'h0);
            issue(RES_IMM, MEM_W, 1'b1, 1'b0, rand_rd(), $urandom, 32'h0);
        end
        bubble(2);
        check_regs();
        end_test();
    endtask

    task automatic load_store_merge();
        logic [2:0] load_ops [5];
        logic [2:0] op;
        load_ops = '{MEM_B, MEM_H, MEM_W, MEM_BU, MEM_HU};
        begin_test("memory");
        // Whole words first, then lane merges on top
        for (int i = 0; i < 8; i++) begin
            issue(RES_ALU, MEM_W, 1'b0, 1'b1, 5'd0, mem_addr(64 + i, 0), $urandom);
        end
        repeat (8) begin
            issue(RES_ALU, MEM_B, 1'b0, 1'b1, 5'd0,
                  mem_addr(64 + $urandom_range(7, 0), $urandom_range(3, 0)), $urandom);
        end
        repeat (8) begin
            issue(RES_ALU, MEM_H, 1'b0, 1'b1, 5'd0,
                  mem_addr(64 + $urandom_range(7, 0), load_offset(MEM_H)), $urandom);
        end
        for (int k = 0; k < 5; k++) begin
            op = load_ops[k];
            repeat (6) begin
                issue(RES_MEM, op, 1'b1, 1'b0, rand_rd(),
                      mem_addr(64 + $urandom_range(7, 0), load_offset(op)), 32'h0);
            end
        end
        // Load right behind a store to the same byte
        issue(RES_ALU, MEM_B, 1'b0, 1'b1, 5'd0, mem_addr(70, 3), $urandom);
        issue(RES_MEM, MEM_B, 1'b1, 1'b0, rand_rd(), mem_addr(70, 3), 32'h0);
        bubble(2);
        check_regs();
        end_test();
    endtask

    task automatic ignored_writes();
        begin_test("no_write");
        repeat (6) begin
            issue(RES_ALU, MEM_W, 1'b1, 1'b0, 5'd0, $urandom, 32'h0);
        end
        repeat (6) begin
            issue(RES_IMM, MEM_W, 1'b0, 1'b0, rand_rd(), $urandom, 32'h0);
        end
        bubble(2);
        check_regs();
        end_test();
    endtask

    task automatic stall_and_release();
        begin_test("stall");
        repeat (3) begin
            issue(RES_ALU, MEM_W, 1'b1, 1'b0, rand_rd(), $urandom, 32'h0);
        end
        hold_pipeline(5);
        repeat (3) begin
            issue(RES_PC_PLUS4, MEM_W, 1'b1, 1'b0, rand_rd(), $urandom, 32'h0);
        end
        bubble(2);
        check_regs();
        end_test();
    endtask

    // Compare at the falling edge, then advance the model for the next rising edge
    always @(negedge clk_i) begin
        if (rst_i) begin
            stage_m = '0;
            stage_w = '0;
        end else begin
            if (stage_w.valid) begin
                n_checks++;
                if (reg_write_w_o !== stage_w.rw) begin
                    mismatch("reg_write_w_o", stage_w.rw, reg_write_w_o);
                end
                if (stage_w.rw) begin
                    n_checks++;
                    if (rd_w_o !== stage_w.rd) begin
                        mismatch("rd_w_o", stage_w.rd, rd_w_o);
                    end
                    n_checks++;
                    if (result_w_o !== stage_w.result) begin
                        mismatch("result_w_o", stage_w.result, result_w_o);
                    end
                end
                // Stalled slot is checked again next cycle
                if (!stall_i) begin
                    in_flight--;
                end
            end
            if (!stall_i) begin
                stage_w = stage_m;
                if (exp_q.size() > 0) begin
                    stage_m = exp_q.pop_front();
                end else begin
                    stage_m = '0;
                end
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        clk_i          = 1'b0;
        rst_i          = 1'b1;
        stall_i        = 1'b0;
        alu_result_e_i = '0;
        write_data_e_i = '0;
        pc_target_e_i  = '0;
        pc_plus4_e_i   = '0;
        imm_ext_e_i    = '0;
        rd_e_i         = '0;
        result_src_e_i = RES_ALU;
        mem_op_e_i     = MEM_W;
        reg_write_e_i  = 1'b0;
        mem_write_e_i  = 1'b0;
        rs1_addr_i     = '0;
        rs2_addr_i     = '0;
        in_flight      = 0;
        n_checks       = 0;
        n_errors       = 0;
        timed_out      = 1'b0;
        cur_test       = "init";
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end

        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;

        reset_state();
        if (!timed_out) random_alu_writes();
        if (!timed_out) result_sources();
        if (!timed_out) load_store_merge();
        if (!timed_out) ignored_writes();
        if (!timed_out) stall_and_release();

        $display("Summary: %0d checks, %0d errors, timeout %0d", n_checks, n_errors, timed_out);
        if (n_errors == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== rv_backend.f ====
rv_backend_pkg.sv
mem_wb_if.sv
load_reducer.sv
data_memory.sv
memory_stage.sv
writeback_stage.sv
register_file.sv
rv_backend_top.sv
tb_rv_backend.sv
